// ==== hdl/burstPkg.sv ====
//--------------------------------------------------
// Lane and header types, the per-lane job and the
// keystream used by the cipher lanes
//--------------------------------------------------
package burstPkg;

	localparam int LaneWidth = 32;

	typedef logic [LaneWidth-1:0] laneT;

	// Lane 0 of every bucket header carries this
	typedef logic [LaneWidth-1:0] nonceT;

	typedef struct packed {
		laneT data;
		logic isWrite;
		logic isHeader;
		laneT bucketIdx;
		logic [7:0] burstIdx;
		nonceT nonce;
	} laneJobT;

	//--------------------------------------------------
	// Keyed mixer. Every step is a bijection in x, so a
	// new nonce always gives a new keystream word
	//--------------------------------------------------
	function automatic laneT laneKeystream(input laneT key, input laneT bucketIdx,
			input logic [7:0] burstIdx, input logic [7:0] lane, input nonceT nonce);
		laneT x;
		x = nonce ^ key;
		x = x + bucketIdx * 32'h9E3779B1;
		x = x ^ {burstIdx, lane, burstIdx ^ lane, 8'hA5};
		x = x * 32'h85EBCA6B;
		x = x ^ (x >> 13);
		x = x * 32'hC2B2AE35;
		x = x ^ (x >> 16);
		return x;
	endfunction

endpackage

// ==== hdl/oramGeometryPkg.sv ====
//--------------------------------------------------
// Tree geometry, index types and the path, DRAM and
// bucket context structs
//--------------------------------------------------
package oramGeometryPkg;
	import burstPkg::*;

	// Deepest tree the index types are sized for
	localparam int MaxLevels = 15;

	typedef logic [MaxLevels-1:0] leafT;

	// Heap order, root bucket is 0
	typedef logic [MaxLevels:0] bucketIdxT;

	typedef logic [31:0] dramAddrT;

	typedef struct packed {
		logic isWrite;
		leafT leaf;
	} pathCmdT;

	// One command moves all bursts of one bucket
	typedef struct packed {
		dramAddrT addr;
		logic isWrite;
	} dramCmdT;

	typedef struct packed {
		logic isWrite;
		bucketIdxT bucketIdx;
		nonceT nonce;
	} bucketCtxT;

endpackage

// ==== hdl/pathBuffer.sv ====
//--------------------------------------------------
// Circular FIFO with a type parameter payload
//--------------------------------------------------
`timescale 1ns/1ps

module pathBuffer #(
	parameter type payloadT = logic [31:0],
	parameter int Depth = 4
) (
	input logic Clock,
	input logic reset,
	input payloadT inData,
	input logic inValid,
	output logic inReady,
	output payloadT outData,
	output logic outValid,
	input logic outReady,
	output logic room
);

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam logic [PtrWidth:0] Full = (PtrWidth + 1)'(Depth);
	localparam logic [PtrWidth-1:0] LastSlot = PtrWidth'(Depth - 1);

	payloadT mem [Depth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [PtrWidth:0] count;
	logic push;
	logic pop;

	assign inReady = (count != Full);
	assign outValid = (count != '0);
	// Whole buffer free
	assign room = (count == '0);
	assign outData = mem[rdPtr];

	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_ff @(posedge Clock) begin
		if (push)
			mem[wrPtr] <= inData;
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == LastSlot) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == LastSlot) ? '0 : rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Upstream only offers data when there is space
	noOverflow: assert property (@(posedge Clock) disable iff (reset)
		inValid |-> inReady)
		else $error("write offered to a full buffer");

endmodule

// ==== hdl/pathAddresser.sv ====
//--------------------------------------------------
// Path command walker: one DRAM command and one
// bucket context per level, plus the write nonce
//--------------------------------------------------
`timescale 1ns/1ps

module pathAddresser
	import oramGeometryPkg::*, burstPkg::*;
#(
	parameter int OramLevels = 3,
	parameter int BucketBursts = 3
) (
	input logic Clock,
	input logic reset,
	input pathCmdT cmd,
	input logic cmdValid,
	output logic cmdReady,
	output dramCmdT dramCmd,
	output logic dramCmdValid,
	input logic dramCmdReady,
	output bucketCtxT ctx,
	output logic ctxValid,
	input logic ctxReady,
	input logic readRoom
);

	localparam int LevelWidth = $clog2(MaxLevels + 1);
	typedef logic [LevelWidth-1:0] levelT;
	localparam levelT LastLevel = levelT'(OramLevels);

	logic busy;
	levelT level;
	logic isWriteReg;
	leafT leafReg;
	nonceT nonceCount;
	nonceT pathNonce;
	bucketIdxT bucketIdx;
	logic fire;
	logic step;

	// Reads wait until nothing is outstanding, since DRAM read data cannot stall
	assign cmdReady = !busy && (cmd.isWrite || readRoom);
	assign fire = cmdValid && cmdReady;

	// Command and context move together
	assign dramCmdValid = busy && ctxReady;
	assign ctxValid = dramCmdValid && dramCmdReady;
	assign step = ctxValid;

	// 2^l - 1 + (leaf >> (L - l))
	assign bucketIdx = (bucketIdxT'(1) << level) - bucketIdxT'(1)
		+ bucketIdxT'(leafReg >> (LastLevel - level));

	assign dramCmd.addr = dramAddrT'(bucketIdx) * dramAddrT'(BucketBursts);
	assign dramCmd.isWrite = isWriteReg;
	assign ctx.isWrite = isWriteReg;
	assign ctx.bucketIdx = bucketIdx;
	assign ctx.nonce = pathNonce;

	always_ff @(posedge Clock) begin
		if (reset) begin
			busy <= 1'b0;
			level <= '0;
			nonceCount <= '0;
		end else if (fire) begin
			busy <= 1'b1;
			level <= '0;
			if (cmd.isWrite)
				nonceCount <= nonceCount + 1'b1;
		end else if (step) begin
			if (level == LastLevel)
				busy <= 1'b0;
			else
				level <= level + 1'b1;
		end
	end

	// Path payload, latched on accept
	always_ff @(posedge Clock) begin
		if (fire) begin
			isWriteReg <= cmd.isWrite;
			leafReg <= cmd.leaf;
			pathNonce <= nonceCount;
		end
	end

	levelBound: assert property (@(posedge Clock) disable iff (reset)
		busy |-> level <= LastLevel)
		else $error("level walked past the leaf");

endmodule

// ==== hdl/laneFeeder.sv ====
//--------------------------------------------------
// Builds lane jobs per bucket burst, strips read
// headers and inserts write headers
//--------------------------------------------------
`timescale 1ns/1ps

module laneFeeder
	import oramGeometryPkg::*, burstPkg::*;
#(
	parameter int OramLevels = 3,
	parameter int BucketBursts = 3,
	parameter int LaneCount = 4
) (
	input logic Clock,
	input logic reset,
	input bucketCtxT ctx,
	input logic ctxValid,
	output logic ctxReady,
	input laneT [LaneCount-1:0] dramData,
	input logic dramDataValid,
	output logic dramDataReady,
	input laneT [LaneCount-1:0] writeData,
	input logic writeDataValid,
	output logic writeDataReady,
	output laneJobT [LaneCount-1:0] jobs,
	output logic jobsValid,
	input logic [LaneCount-1:0] jobsReady
);

	localparam logic [7:0] LastBurst = 8'(BucketBursts - 1);
	localparam bucketIdxT BucketsInTree = bucketIdxT'((2 << OramLevels) - 1);

	logic [7:0] burstCnt;
	logic headerBurst;
	logic lastBurst;
	logic allReady;
	logic advance;
	nonceT readNonce;
	nonceT jobNonce;
	laneT [LaneCount-1:0] srcData;

	assign allReady = &jobsReady;
	assign headerBurst = (burstCnt == '0);
	assign lastBurst = (burstCnt == LastBurst);

	// Write nonce comes with the context, read nonce from the header
	assign jobNonce = ctx.isWrite ? ctx.nonce : readNonce;

	//--------------------------------------------------
	// Stream selection and handshakes
	//--------------------------------------------------
	always_comb begin
		jobsValid = 1'b0;
		dramDataReady = 1'b0;
		writeDataReady = 1'b0;
		advance = 1'b0;
		if (ctxValid) begin
			if (ctx.isWrite) begin
				jobsValid = headerBurst || writeDataValid;
				writeDataReady = !headerBurst && allReady;
				advance = jobsValid && allReady;
			end else begin
				// Header is swallowed here
				jobsValid = !headerBurst && dramDataValid;
				dramDataReady = headerBurst || allReady;
				advance = dramDataValid && dramDataReady;
			end
		end
		// Context stays at the head until its last burst
		ctxReady = advance && lastBurst;
	end

	always_comb begin
		srcData = ctx.isWrite ? writeData : dramData;
		if (headerBurst) begin
			srcData = '0;
			srcData[0] = ctx.nonce;
		end
	end

	always_comb begin
		for (int i = 0; i < LaneCount; i++) begin
			jobs[i].data = srcData[i];
			jobs[i].isWrite = ctx.isWrite;
			jobs[i].isHeader = headerBurst;
			jobs[i].bucketIdx = laneT'(ctx.bucketIdx);
			jobs[i].burstIdx = burstCnt;
			jobs[i].nonce = jobNonce;
		end
	end

	always_ff @(posedge Clock) begin
		if (reset)
			burstCnt <= '0;
		else if (advance)
			burstCnt <= lastBurst ? '0 : burstCnt + 1'b1;
	end

	always_ff @(posedge Clock) begin
		if (ctxValid && !ctx.isWrite && headerBurst && dramDataValid)
			readNonce <= dramData[0];
	end

	bucketInTree: assert property (@(posedge Clock) disable iff (reset)
		ctxValid |-> ctx.bucketIdx < BucketsInTree)
		else $error("context bucket outside the tree");

endmodule

// ==== hdl/cipherLane.sv ====
//--------------------------------------------------
// One-stage cipher lane, counter mode on one word
//--------------------------------------------------
`timescale 1ns/1ps

module cipherLane
	import burstPkg::*;
#(
	parameter int LaneIdx = 0,
	parameter laneT CipherKey = 32'h3C6EF372
) (
	input logic Clock,
	input logic reset,
	input laneJobT job,
	input logic jobValid,
	output logic jobReady,
	output laneT result,
	output logic resultIsWrite,
	output logic resultValid,
	input logic resultReady
);

	laneT keystream;

	assign keystream = laneKeystream(CipherKey, job.bucketIdx, job.burstIdx,
		8'(LaneIdx), job.nonce);

	// Take a new job when empty or when the held one leaves
	assign jobReady = !resultValid || resultReady;

	always_ff @(posedge Clock) begin
		if (reset)
			resultValid <= 1'b0;
		else if (jobReady)
			resultValid <= jobValid;
	end

	always_ff @(posedge Clock) begin
		if (jobReady && jobValid) begin
			// Headers go out in the clear
			result <= job.isHeader ? job.data : job.data ^ keystream;
			resultIsWrite <= job.isWrite;
		end
	end

	holdWhileStalled: assert property (@(posedge Clock) disable iff (reset)
		resultValid && !resultReady |=>
			resultValid && $stable(result) && $stable(resultIsWrite))
		else $error("lane %0d dropped or changed a stalled result", LaneIdx);

endmodule

// ==== hdl/burstMerger.sv ====
//--------------------------------------------------
// Gathers lane results and steers each burst
//--------------------------------------------------
`timescale 1ns/1ps

module burstMerger
	import burstPkg::*;
#(
	parameter int LaneCount = 4
) (
	input laneT [LaneCount-1:0] results,
	input logic [LaneCount-1:0] resultIsWrite,
	input logic [LaneCount-1:0] resultValid,
	output logic resultReady,
	output laneT [LaneCount-1:0] dramWriteData,
	output logic dramWriteDataValid,
	input logic dramWriteDataReady,
	output laneT [LaneCount-1:0] readData,
	output logic readDataValid,
	input logic readDataReady
);

	logic burstValid;
	logic toDram;

	// Lanes run in lockstep, so all must be valid together
	assign burstValid = &resultValid;
	assign toDram = resultIsWrite[0];

	assign dramWriteData = results;
	assign readData = results;
	assign dramWriteDataValid = burstValid && toDram;
	assign readDataValid = burstValid && !toDram;

	// Ready of the selected sink only
	assign resultReady = toDram ? dramWriteDataReady : readDataReady;

endmodule

// ==== hdl/pathOramDatapath.sv ====
//--------------------------------------------------
// DRAM-side Path ORAM datapath top level
//--------------------------------------------------
`timescale 1ns/1ps

module pathOramDatapath
	import oramGeometryPkg::*, burstPkg::*;
#(
	parameter int OramLevels = 3,
	parameter int BucketBursts = 3,
	parameter int LaneCount = 4,
	parameter laneT CipherKey = 32'h3C6EF372
) (
	input logic Clock,
	input logic reset,
	input pathCmdT cmd,
	input logic cmdValid,
	output logic cmdReady,
	input laneT [LaneCount-1:0] writeData,
	input logic writeDataValid,
	output logic writeDataReady,
	output laneT [LaneCount-1:0] readData,
	output logic readDataValid,
	input logic readDataReady,
	output dramCmdT dramCmd,
	output logic dramCmdValid,
	input logic dramCmdReady,
	input laneT [LaneCount-1:0] dramReadData,
	input logic dramReadDataValid,
	output laneT [LaneCount-1:0] dramWriteData,
	output logic dramWriteDataValid,
	input logic dramWriteDataReady
);

	localparam int PathBuckets = OramLevels + 1;
	localparam int PathBursts = PathBuckets * BucketBursts;

	typedef laneT [LaneCount-1:0] burstT;

	//--------------------------------------------------
	// Wires
	//--------------------------------------------------
	bucketCtxT ctxIn, ctxOut;
	logic ctxInValid, ctxInReady, ctxOutValid, ctxOutReady;
	logic readRoom;

	burstT bufData;
	logic bufValid, bufReady;

	laneJobT [LaneCount-1:0] jobs;
	logic jobsValid;
	logic [LaneCount-1:0] laneReady;

	laneT [LaneCount-1:0] laneResult;
	logic [LaneCount-1:0] laneIsWrite, laneValid;
	logic resultReady;

	//--------------------------------------------------
	// Addressing and buffers
	//--------------------------------------------------
	pathAddresser #(.OramLevels(OramLevels), .BucketBursts(BucketBursts)) i_addresser (
		.Clock(Clock), .reset(reset),
		.cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
		.dramCmd(dramCmd), .dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.ctx(ctxIn), .ctxValid(ctxInValid), .ctxReady(ctxInReady),
		.readRoom(readRoom));

	// Empty context queue means no bucket is still in flight
	pathBuffer #(.payloadT(bucketCtxT), .Depth(PathBuckets)) i_ctxBuffer (
		.Clock(Clock), .reset(reset),
		.inData(ctxIn), .inValid(ctxInValid), .inReady(ctxInReady),
		.outData(ctxOut), .outValid(ctxOutValid), .outReady(ctxOutReady),
		.room(readRoom));

	pathBuffer #(.payloadT(burstT), .Depth(PathBursts)) i_readBuffer (
		.Clock(Clock), .reset(reset),
		.inData(dramReadData), .inValid(dramReadDataValid), .inReady(),
		.outData(bufData), .outValid(bufValid), .outReady(bufReady),
		.room());

	//--------------------------------------------------
	// Cipher bank
	//--------------------------------------------------
	laneFeeder #(.OramLevels(OramLevels), .BucketBursts(BucketBursts),
		.LaneCount(LaneCount)) i_feeder (
		.Clock(Clock), .reset(reset),
		.ctx(ctxOut), .ctxValid(ctxOutValid), .ctxReady(ctxOutReady),
		.dramData(bufData), .dramDataValid(bufValid), .dramDataReady(bufReady),
		.writeData(writeData), .writeDataValid(writeDataValid),
		.writeDataReady(writeDataReady),
		.jobs(jobs), .jobsValid(jobsValid), .jobsReady(laneReady));

	for (genvar i = 0; i < LaneCount; i++) begin : gLane
		cipherLane #(.LaneIdx(i), .CipherKey(CipherKey)) i_lane (
			.Clock(Clock), .reset(reset),
			.job(jobs[i]), .jobValid(jobsValid), .jobReady(laneReady[i]),
			.result(laneResult[i]), .resultIsWrite(laneIsWrite[i]),
			.resultValid(laneValid[i]), .resultReady(resultReady));
	end

	burstMerger #(.LaneCount(LaneCount)) i_merger (
		.results(laneResult), .resultIsWrite(laneIsWrite),
		.resultValid(laneValid), .resultReady(resultReady),
		.dramWriteData(dramWriteData), .dramWriteDataValid(dramWriteDataValid),
		.dramWriteDataReady(dramWriteDataReady),
		.readData(readData), .readDataValid(readDataValid),
		.readDataReady(readDataReady));

endmodule

// ==== tb/pathOramDatapathTb.sv ====
//--------------------------------------------------
// Testbench for the Path ORAM datapath: DRAM model,
// stimulus table, bucket reference model and checks
//--------------------------------------------------
`timescale 1ns/1ps

module pathOramDatapathTb
	import oramGeometryPkg::*, burstPkg::*;
();

	localparam int OramLevels = 3;
	localparam int BucketBursts = 3;
	localparam int LaneCount = 4;
	localparam laneT CipherKey = 32'h3C6EF372;
	localparam int PathBuckets = OramLevels + 1;
	localparam int PathBursts = PathBuckets * BucketBursts;
	localparam int DataBursts = BucketBursts - 1;
	localparam int MemBursts = ((2 << OramLevels) - 1) * BucketBursts;
	localparam int ClockPeriod = 40;
	localparam int ReadDelay = 3;

	typedef laneT [LaneCount-1:0] burstT;
	typedef logic [LaneCount*LaneWidth-1:0] wideT;

	typedef struct packed {
		logic isWrite;
		leafT leaf;
		logic [7:0] dataSeed;
	} opEntryT;

	//--------------------------------------------------
	// Stimulus table: direction, leaf, plaintext seed
	//--------------------------------------------------
	localparam int NumOps = 13;
	localparam opEntryT OpTable [NumOps] = '{
		'{1'b1, leafT'(5), 8'd1}, '{1'b0, leafT'(5), 8'd0}, '{1'b1, leafT'(3), 8'd2},
		'{1'b0, leafT'(5), 8'd0}, '{1'b1, leafT'(5), 8'd1}, '{1'b1, leafT'(5), 8'd1},
		'{1'b0, leafT'(3), 8'd0}, '{1'b1, leafT'(0), 8'd3}, '{1'b0, leafT'(1), 8'd0},
		'{1'b0, leafT'(5), 8'd0}, '{1'b1, leafT'(7), 8'd4}, '{1'b0, leafT'(7), 8'd0},
		'{1'b0, leafT'(6), 8'd0}
	};
	localparam int WatchdogNs = NumOps * PathBursts * ClockPeriod * 20;

	logic Clock;
	logic reset;
	pathCmdT cmd;
	logic cmdValid, cmdReady;
	burstT writeData, readData, dramReadData, dramWriteData;
	logic writeDataValid, writeDataReady, readDataValid, readDataReady;
	dramCmdT dramCmd;
	logic dramCmdValid, dramCmdReady, dramReadDataValid;
	logic dramWriteDataValid, dramWriteDataReady;

	// DRAM contents and the plaintext last written per burst address
	burstT dramMem [MemBursts];
	bit memStored [MemBursts];
	burstT refPlain [MemBursts];
	bit refWritten [MemBursts];

	int readAddrQ [$];
	int writeAddrQ [$];
	burstT plainQ [$];
	burstT expReadQ [$];
	bit expCheckQ [$];

	int stallSeed = 27;
	int cmdCount = 0;
	int writeBurstCount = 0;
	int readBurstCount = 0;
	int rewriteChecks = 0;
	int writeOffset = 0;
	int pathCmdBase = 0;
	logic curIsWrite = 1'b0;
	leafT curLeaf = '0;
	nonceT curNonce = '0;

	pathOramDatapath #(.OramLevels(OramLevels), .BucketBursts(BucketBursts),
		.LaneCount(LaneCount), .CipherKey(CipherKey)) i_dut (
		.Clock(Clock), .reset(reset),
		.cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
		.writeData(writeData), .writeDataValid(writeDataValid),
		.writeDataReady(writeDataReady),
		.readData(readData), .readDataValid(readDataValid), .readDataReady(readDataReady),
		.dramCmd(dramCmd), .dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.dramReadData(dramReadData), .dramReadDataValid(dramReadDataValid),
		.dramWriteData(dramWriteData), .dramWriteDataValid(dramWriteDataValid),
		.dramWriteDataReady(dramWriteDataReady));

	task automatic expectEqual(input wideT actual, input wideT expected, input string what);
		if (actual !== expected) begin
			$display("FAILED at %0d ns: %s (got %h, expected %h)", $time, what, actual,
				expected);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Heap index of the level-l bucket on the path to a leaf
	function automatic int bucketOnPath(input leafT leaf, input int level);
		return (1 << level) - 1 + int'(leaf >> (OramLevels - level));
	endfunction

	function automatic burstT fillPattern(input int addr);
		burstT fill;
		for (int ln = 0; ln < LaneCount; ln++)
			fill[ln] = laneT'(addr) * 32'h01000193 + laneT'(ln) + 32'h5A000000;
		return fill;
	endfunction

	initial begin : clockGen
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	initial begin : watchdog
		#(WatchdogNs);
		$display("ERROR: timeout, the paths did not complete within %0d ns", WatchdogNs);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin : readyStalls
		int r;
		readDataReady = 1'b0;
		dramWriteDataReady = 1'b0;
		forever begin
			@(posedge Clock);
			#2;
			r = $random(stallSeed);
			readDataReady = (r[1:0] != 2'b00);
			dramWriteDataReady = (r[3:2] != 2'b00);
		end
	end

	//--------------------------------------------------
	// DRAM model
	//--------------------------------------------------
	initial begin : dramReader
		int addr;
		dramReadData = '0;
		dramReadDataValid = 1'b0;
		forever begin
			@(posedge Clock);
			if (readAddrQ.size() > 0) begin
				addr = readAddrQ.pop_front();
				repeat (ReadDelay - 1) @(posedge Clock);
				for (int k = 0; k < BucketBursts; k++) begin
					#2;
					dramReadData = memStored[addr + k] ? dramMem[addr + k] : fillPattern(addr + k);
					dramReadDataValid = 1'b1;
					@(posedge Clock);
				end
				#2;
				dramReadDataValid = 1'b0;
			end
		end
	end

	always @(negedge Clock) begin : dramCmdMonitor
		int addr;
		if (!reset && dramCmdValid && dramCmdReady) begin
			addr = bucketOnPath(curLeaf, cmdCount - pathCmdBase) * BucketBursts;
			expectEqual(wideT'(dramCmd.addr), wideT'(addr), "DRAM command address");
			expectEqual(wideT'(dramCmd.isWrite), wideT'(curIsWrite), "DRAM command direction");
			cmdCount++;
			if (dramCmd.isWrite)
				writeAddrQ.push_back(addr);
			else
				readAddrQ.push_back(addr);
		end
	end

	always @(negedge Clock) begin : dramWriteMonitor
		int addr;
		burstT plain;
		burstT header;
		if (!reset && dramWriteDataValid && dramWriteDataReady) begin
			expectEqual(wideT'(writeAddrQ.size() > 0), wideT'(1), "DRAM write without command");
			addr = writeAddrQ[0] + writeOffset;
			if (writeOffset == 0) begin
				header = '0;
				header[0] = curNonce;
				expectEqual(wideT'(dramWriteData), wideT'(header), "bucket header");
			end else begin
				expectEqual(wideT'(plainQ.size() > 0), wideT'(1), "DRAM data burst not sent");
				plain = plainQ.pop_front();
				// Same plaintext again must still give new ciphertext
				if (refWritten[addr] && refPlain[addr] == plain) begin
					expectEqual(wideT'(dramWriteData != dramMem[addr]), wideT'(1),
						"ciphertext repeated for a rewrite");
					rewriteChecks++;
				end
				refPlain[addr] = plain;
				refWritten[addr] = 1'b1;
			end
			dramMem[addr] = dramWriteData;
			memStored[addr] = 1'b1;
			writeBurstCount++;
			if (writeOffset == BucketBursts - 1) begin
				writeOffset = 0;
				void'(writeAddrQ.pop_front());
			end else
				writeOffset++;
		end
	end

	always @(negedge Clock) begin : readMonitor
		burstT expected;
		bit check;
		if (!reset && readDataValid && readDataReady) begin
			expectEqual(wideT'(expReadQ.size() > 0), wideT'(1), "unexpected read burst");
			expected = expReadQ.pop_front();
			check = expCheckQ.pop_front();
			// Buckets never written hold no defined plaintext
			if (check)
				expectEqual(wideT'(readData), wideT'(expected), "read plaintext");
			readBurstCount++;
		end
	end

	//--------------------------------------------------
	// Stimulus
	//--------------------------------------------------
	task automatic sendCommand(input opEntryT op);
		cmd.isWrite = op.isWrite;
		cmd.leaf = op.leaf;
		cmdValid = 1'b1;
		@(negedge Clock);
		while (!cmdReady)
			@(negedge Clock);
		@(posedge Clock);
		#2;
		cmdValid = 1'b0;
	endtask

	task automatic sendWriteBurst(input burstT plain);
		writeData = plain;
		writeDataValid = 1'b1;
		@(negedge Clock);
		while (!writeDataReady)
			@(negedge Clock);
		@(posedge Clock);
		#2;
		writeDataValid = 1'b0;
	endtask

	task automatic runPath(input opEntryT op);
		int dataState;
		int addr;
		int target;
		burstT plain;
		curIsWrite = op.isWrite;
		curLeaf = op.leaf;
		pathCmdBase = cmdCount;
		if (!op.isWrite) begin
			for (int l = 0; l < PathBuckets; l++)
				for (int k = 1; k <= DataBursts; k++) begin
					addr = bucketOnPath(op.leaf, l) * BucketBursts + k;
					expReadQ.push_back(refPlain[addr]);
					expCheckQ.push_back(refWritten[addr]);
				end
		end
		sendCommand(op);
		if (op.isWrite) begin
			target = writeBurstCount + PathBursts;
			dataState = 27 + 1000 * int'(op.dataSeed);
			for (int b = 0; b < PathBuckets * DataBursts; b++) begin
				for (int ln = 0; ln < LaneCount; ln++)
					plain[ln] = $random(dataState);
				plainQ.push_back(plain);
				sendWriteBurst(plain);
			end
			wait (writeBurstCount == target);
			curNonce = curNonce + 1'b1;
		end else begin
			target = readBurstCount + PathBuckets * DataBursts;
			wait (readBurstCount == target);
		end
		expectEqual(wideT'(cmdCount - pathCmdBase), wideT'(PathBuckets), "DRAM commands per path");
		@(posedge Clock);
		#2;
	endtask

	initial begin : stimulus
		int writePaths;
		reset = 1'b1;
		cmd = '0;
		cmdValid = 1'b0;
		writeData = '0;
		writeDataValid = 1'b0;
		dramCmdReady = 1'b0;
		repeat (2) @(posedge Clock);
		#2;
		reset = 1'b0;
		dramCmdReady = 1'b1;
		@(negedge Clock);
		expectEqual(wideT'(cmdReady), wideT'(1), "cmdReady after reset");
		expectEqual(wideT'({readDataValid, dramCmdValid, dramWriteDataValid}), wideT'(0),
			"valid outputs after reset");
		@(posedge Clock);
		#2;
		writePaths = 0;
		for (int i = 0; i < NumOps; i++) begin
			runPath(OpTable[i]);
			if (OpTable[i].isWrite)
				writePaths++;
		end
		// Idle time to catch duplicated bursts
		repeat (20) @(posedge Clock);
		expectEqual(wideT'(cmdCount), wideT'(NumOps * PathBuckets), "total DRAM commands");
		expectEqual(wideT'(writeBurstCount), wideT'(writePaths * PathBursts),
			"total DRAM write bursts");
		expectEqual(wideT'(readBurstCount),
			wideT'((NumOps - writePaths) * PathBuckets * DataBursts), "total read bursts");
		expectEqual(wideT'(rewriteChecks > 0), wideT'(1), "rewrite of same plaintext seen");
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== pathOramDatapath.f ====
hdl/burstPkg.sv
hdl/oramGeometryPkg.sv
hdl/pathBuffer.sv
hdl/pathAddresser.sv
hdl/laneFeeder.sv
hdl/cipherLane.sv
hdl/burstMerger.sv
hdl/pathOramDatapath.sv
tb/pathOramDatapathTb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := pathOramDatapathTb
FILELIST := pathOramDatapath.f
BUILD    := obj_dir
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
